//--- vlog.f
+incdir+include
verilog/cpu_pkg.sv
verilog/fetch_decode.sv
verilog/exec_unit.sv
verilog/io_mem.sv
verilog/cpu_top.sv
verif/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --assert -f vlog.f --top-module cpu_tb -o cpu_tb_sim \
    && ./obj_dir/cpu_tb_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

//--- verif/cpu_tb.sv
module cpu_tb import cpu_pkg::*; ();

    localparam int num_rows = 10;

    logic              clk;
    logic              rst;
    logic [data_w-1:0] rx_data;
    logic              rx_avail;
    logic              rx_take;
    logic [data_w-1:0] tx_data;
    logic              tx_strobe;
    logic              tx_ready;

    // Test table, expected columns filled from the arithmetic rules
    string             tab_name [num_rows];
    logic [data_w-1:0] tab_a    [num_rows];
    logic [data_w-1:0] tab_b    [num_rows];
    logic [2:0]        tab_mask [num_rows];   // Bit 0 row start, bits 1 and 2 after a strobe
    int                tab_len  [num_rows];   // Stall length in cycles
    logic [data_w-1:0] exp_sum  [num_rows];
    logic [data_w-1:0] exp_diff [num_rows];
    logic [data_w-1:0] exp_max  [num_rows];

    int                seed;
    int                cycles = 0;
    int                limit = 0;
    logic              limit_set = 1'b0;
    int                errors = 0;
    int                fails = 0;

    // Feeder and monitor state
    logic [data_w-1:0] feed [2];
    int                num_feed;
    int                feed_idx;
    int                takes;
    int                got;
    logic [data_w-1:0] got_bytes [3];
    int                stall_left;

    cpu_top i_dut (
        .clk, .rst,
        .rx_data, .rx_avail, .rx_take,
        .tx_data, .tx_strobe, .tx_ready
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    // Watchdog
    initial begin
        wait (limit_set && cycles >= limit);
        $display("Timeout after %0d cycles, the program stopped producing output", cycles);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    task automatic set_row(input int idx, input string name, input logic [data_w-1:0] a,
                           input logic [data_w-1:0] b, input logic [2:0] mask);
        tab_name[idx] = name;
        tab_a[idx]    = a;
        tab_b[idx]    = b;
        tab_mask[idx] = mask;
    endtask

    task automatic fill_table();
        set_row(0, "small", 8'd5, 8'd3, 3'b000);
        set_row(1, "carry", 8'd200, 8'd100, 3'b000);    // Sum wraps
        set_row(2, "borrow", 8'd3, 8'd10, 3'b001);      // b above a
        set_row(3, "equal", 8'd77, 8'd77, 3'b010);
        set_row(4, "zeros", 8'd0, 8'd0, 3'b100);
        set_row(5, "all_ones", 8'hff, 8'hff, 3'b111);
        set_row(6, "b_max", 8'd1, 8'hff, 3'b011);
        set_row(7, "sign_ovf", 8'd127, 8'd128, 3'b101);
        set_row(8, "random_0", data_w'($random(seed)), data_w'($random(seed)), 3'b111);
        set_row(9, "random_1", data_w'($random(seed)), data_w'($random(seed)), 3'b110);
        for (int i = 0; i < num_rows; i++) begin
            tab_len[i]  = int'($random(seed) & 32'hf) + 10;   // Long enough to reach a transmit
            exp_sum[i]  = tab_a[i] + tab_b[i];
            exp_diff[i] = tab_a[i] - tab_b[i];
            exp_max[i]  = (tab_b[i] > tab_a[i]) ? tab_b[i] : tab_a[i];   // Ties give a
        end
    endtask

    task automatic check_byte(input string name, input logic [data_w-1:0] exp,
                              input logic [data_w-1:0] act);
        if (act !== exp) begin
            $display("** Error: %s expected 0x%02h actual 0x%02h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error: %s expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // One clock, sampled mid cycle and driven just after the edge
    task automatic run_cycle(input string name, input logic [2:0] mask, input int len);
        logic took;
        logic sent;
        @(negedge clk);
        took = rx_take;
        sent = tx_strobe;
        if (rx_take && !rx_avail) begin
            $display("%s: rx_take pulsed with no receive data available", name);
            errors++;
        end
        if (tx_strobe && !tx_ready) begin
            $display("%s: byte transmitted while the transmitter was not ready", name);
            errors++;
        end
        if (took) takes++;
        if (sent) begin
            if (got < 3) begin
                got_bytes[got] = tx_data;
            end else begin
                $display("%s: extra byte 0x%02h transmitted", name, tx_data);
                errors++;
            end
            got++;
        end
        @(posedge clk);
        #1;
        if (took) feed_idx++;                         // Byte consumed at this edge
        if (feed_idx < num_feed) begin
            rx_avail = 1'b1;
            rx_data  = feed[feed_idx];
        end else begin
            rx_avail = 1'b0;
            rx_data  = '0;
        end
        if (stall_left > 0) stall_left--;
        if (sent && got < 3 && mask[got]) stall_left = len;   // Hold off the next byte
        tx_ready = (stall_left == 0);
    endtask

    task automatic idle_after_reset();
        int err0;
        err0     = errors;
        num_feed = 0;
        feed_idx = 0;
        takes    = 0;
        got      = 3;                                 // Any strobe here is an extra one
        repeat (20) run_cycle("reset_idle", 3'b000, 0);
        check_count("reset_idle rx_take", 0, takes);
        if (errors == err0) begin
            $display("test reset_idle ok");
        end else begin
            $display("test reset_idle failed");
            fails++;
        end
    endtask

    task automatic run_row(input int i);
        int err0;
        err0       = errors;
        feed[0]    = tab_a[i];
        feed[1]    = tab_b[i];
        num_feed   = 2;
        feed_idx   = 0;
        takes      = 0;
        got        = 0;
        rx_avail   = 1'b1;
        rx_data    = feed[0];
        stall_left = tab_mask[i][0] ? tab_len[i] : 0;
        tx_ready   = (stall_left == 0);
        while (got < 3) run_cycle(tab_name[i], tab_mask[i], tab_len[i]);
        repeat (10) run_cycle(tab_name[i], tab_mask[i], tab_len[i]);   // Catch stray strobes
        stall_left = 0;
        tx_ready   = 1'b1;
        check_byte({tab_name[i], " sum"}, exp_sum[i], got_bytes[0]);
        check_byte({tab_name[i], " diff"}, exp_diff[i], got_bytes[1]);
        check_byte({tab_name[i], " max"}, exp_max[i], got_bytes[2]);
        check_count({tab_name[i], " rx_take"}, 2, takes);
        if (errors == err0) begin
            $display("test %s ok, a 0x%02h b 0x%02h", tab_name[i], tab_a[i], tab_b[i]);
        end else begin
            $display("test %s failed, a 0x%02h b 0x%02h", tab_name[i], tab_a[i], tab_b[i]);
            fails++;
        end
    endtask

    initial begin
        int stall_total;
        seed     = 32'hb49cea9d;
        rst      = 1'b1;
        rx_data  = '0;
        rx_avail = 1'b0;
        tx_ready = 1'b1;
        fill_table();
        stall_total = 0;
        for (int i = 0; i < num_rows; i++) begin
            stall_total += tab_len[i] * $countones(tab_mask[i]);
        end
        limit     = num_rows * 200 + stall_total;
        limit_set = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_after_reset();
        for (int i = 0; i < num_rows; i++) begin
            run_row(i);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", num_rows + 1,
                 num_rows + 1 - fails, fails, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/cpu_top.sv
module cpu_top import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [data_w-1:0] rx_data,
    input  logic              rx_avail,
    output logic              rx_take,
    output logic [data_w-1:0] tx_data,
    output logic              tx_strobe,
    input  logic              tx_ready
);

    // Decoded control
    alu_op_e           alu_op;
    adev_e             a_sel;
    bdev_e             b_sel;
    targ_e             targ;
    addr_mode_e        addr_mode;
    logic [data_w-1:0] immed8;
    logic [data_w-1:0] direct_addr8;
    logic              rx_rd;

    // Data path
    logic [data_w-1:0] result;
    logic [data_w-1:0] flags;
    logic [data_w-1:0] ram_q;
    logic [data_w-1:0] marlo;
    logic [data_w-1:0] marhi;
    logic [data_w-1:0] rx_q;

    fetch_decode i_fetch (
        .clk, .rst,
        .rx_avail, .tx_ready,
        .flags, .result,
        .alu_op, .a_sel, .b_sel, .targ, .addr_mode,
        .immed8, .direct_addr8,
        .rx_rd,
        .pc ()                              // Visible in the hierarchy only
    );

    exec_unit i_exec (
        .clk, .rst,
        .alu_op, .a_sel, .b_sel, .targ, .immed8,
        .rx_data (rx_q),
        .ram_q, .marlo, .marhi,
        .result, .flags
    );

    io_mem i_io (
        .clk, .rst,
        .targ, .addr_mode, .direct_addr8, .result,
        .rx_rd, .rx_data, .rx_avail, .tx_ready,
        .ram_q, .marlo, .marhi, .rx_q,
        .rx_take, .tx_data, .tx_strobe
    );

endmodule

//--- verilog/io_mem.sv
module io_mem import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  targ_e             targ,
    input  addr_mode_e        addr_mode,
    input  logic [data_w-1:0] direct_addr8,
    input  logic [data_w-1:0] result,
    input  logic              rx_rd,        // Port read decode from fetch
    input  logic [data_w-1:0] rx_data,
    input  logic              rx_avail,
    input  logic              tx_ready,
    output logic [data_w-1:0] ram_q,
    output logic [data_w-1:0] marlo,
    output logic [data_w-1:0] marhi,
    output logic [data_w-1:0] rx_q,         // Port byte onto the A bus
    output logic              rx_take,
    output logic [data_w-1:0] tx_data,
    output logic              tx_strobe
);

    logic [data_w-1:0] ram [ram_depth];
    logic [data_w-1:0] ram_addr;

    // MARHI is only a spare register, the RAM sees MARLO alone
    always_ff @(posedge clk) begin
        if (rst) begin
            marlo <= '0;
            marhi <= '0;
        end else begin
            if (targ == targ_marlo) marlo <= result;
            if (targ == targ_marhi) marhi <= result;
        end
    end

    assign ram_addr = (addr_mode == direct_mode) ? direct_addr8 : marlo;

    always_ff @(posedge clk) begin
        if (targ == targ_ram) ram[ram_addr] <= result;
    end

    assign ram_q = ram[ram_addr];           // Asynchronous read, like an SRAM

    // Receive side, byte only driven while it is being taken
    assign rx_take = rx_rd;
    assign rx_q    = rx_take ? rx_data : '0;

    // Transmit side
    assign tx_strobe = (targ == targ_uart_tx);
    assign tx_data   = result;

    // Port levels are sampled in fetch, the strobes come out here
    a_tx_ready: assert property (@(posedge clk) disable iff (rst) tx_strobe |-> tx_ready);
    a_rx_avail: assert property (@(posedge clk) disable iff (rst) rx_take |-> rx_avail);

endmodule

//--- verilog/exec_unit.sv
module exec_unit import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  alu_op_e           alu_op,
    input  adev_e             a_sel,
    input  bdev_e             b_sel,
    input  targ_e             targ,
    input  logic [data_w-1:0] immed8,
    input  logic [data_w-1:0] rx_data,     // Port byte as an A source
    input  logic [data_w-1:0] ram_q,
    input  logic [data_w-1:0] marlo,
    input  logic [data_w-1:0] marhi,
    output logic [data_w-1:0] result,
    output logic [data_w-1:0] flags
);

    logic [data_w-1:0]   regs [num_regs];
    logic [num_regs-1:0] reg_wr;
    logic [data_w-1:0]   a_bus;
    logic [data_w-1:0]   b_bus;
    logic [data_w-1:0]   arith_b;          // Second adder operand
    logic                carry_in;
    logic                is_sub;
    logic                is_arith;
    logic [data_w:0]     arith9;           // Sum or difference with carry out
    logic                ovf;
    logic [data_w-1:0]   flags_next;

    // A bus
    always_comb begin
        case (a_sel)
            adev_rega:    a_bus = regs[0];
            adev_regb:    a_bus = regs[1];
            adev_regc:    a_bus = regs[2];
            adev_regd:    a_bus = regs[3];
            adev_marlo:   a_bus = marlo;
            adev_marhi:   a_bus = marhi;
            adev_uart_rx: a_bus = rx_data;
            default:      a_bus = '0;      // adev_zero
        endcase
    end

    // B bus
    always_comb begin
        case (b_sel)
            bdev_rega:  b_bus = regs[0];
            bdev_regb:  b_bus = regs[1];
            bdev_regc:  b_bus = regs[2];
            bdev_regd:  b_bus = regs[3];
            bdev_immed: b_bus = immed8;
            bdev_ram:   b_bus = ram_q;
            bdev_marlo: b_bus = marlo;
            default:    b_bus = marhi;
        endcase
    end

    // Adder operand setup; inc and dec reuse the adder with a constant one
    always_comb begin
        arith_b  = b_bus;
        carry_in = 1'b0;
        is_sub   = 1'b0;
        case (alu_op)
            adc:      carry_in = flags[flag_c];
            sub, cmp: is_sub = 1'b1;
            inc_a:    arith_b = data_w'(1);
            dec_a: begin
                arith_b = data_w'(1);
                is_sub  = 1'b1;
            end
            default: ;
        endcase
    end

    assign is_arith = alu_op inside {add, adc, sub, inc_a, dec_a, cmp};
    assign arith9   = is_sub ? {1'b0, a_bus} - {1'b0, arith_b}
                             : {1'b0, a_bus} + {1'b0, arith_b} + (data_w + 1)'(carry_in);

    // Signed overflow, operand signs against the result sign
    assign ovf = is_sub ? (a_bus[data_w-1] != arith_b[data_w-1]) &&
                          (arith9[data_w-1] != a_bus[data_w-1])
                        : (a_bus[data_w-1] == arith_b[data_w-1]) &&
                          (arith9[data_w-1] != a_bus[data_w-1]);

    always_comb begin
        case (alu_op)
            pass_a:  result = a_bus;
            pass_b:  result = b_bus;
            and_op:  result = a_bus & b_bus;
            or_op:   result = a_bus | b_bus;
            xor_op:  result = a_bus ^ b_bus;
            default: result = arith9[data_w-1:0];   // Adder ops and cmp
        endcase
    end

    always_comb begin
        flags_next          = '0;
        flags_next[flag_c]  = is_arith && arith9[data_w];   // Borrow on subtract
        flags_next[flag_z]  = (result == '0);
        flags_next[flag_o]  = is_arith && ovf;
        flags_next[flag_n]  = result[data_w-1];
        flags_next[flag_gt] = a_bus > b_bus;                // Unsigned compare
        flags_next[flag_lt] = a_bus < b_bus;
        flags_next[flag_eq] = a_bus == b_bus;
        flags_next[flag_ne] = a_bus != b_bus;
    end

    // Flags hold across jumps so a condition can follow its compare
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (targ != targ_pc) begin
            flags <= flags_next;
        end
    end

    assign reg_wr = {targ == targ_regd, targ == targ_regc, targ == targ_regb, targ == targ_rega};

    always_ff @(posedge clk) begin
        for (int i = 0; i < num_regs; i++) begin
            if (reg_wr[i]) regs[i] <= result;
        end
    end

    a_one_reg_wr: assert property (@(posedge clk) disable iff (rst) $onehot0(reg_wr));

    // Compare results only reach the flags
    a_cmp_no_target: assert property (@(posedge clk) disable iff (rst)
        alu_op == cmp |-> targ == targ_none);

endmodule

//--- verilog/fetch_decode.sv
module fetch_decode import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              rx_avail,
    input  logic              tx_ready,
    input  logic [data_w-1:0] flags,
    input  logic [data_w-1:0] result,      // Jump target from the ALU
    output alu_op_e           alu_op,
    output adev_e             a_sel,
    output bdev_e             b_sel,
    output targ_e             targ,
    output addr_mode_e        addr_mode,
    output logic [data_w-1:0] immed8,
    output logic [data_w-1:0] direct_addr8,
    output logic              rx_rd,       // Port read decode
    output logic [pc_w-1:0]   pc
);

    `include "program_image.svh"

    logic [instr_w-1:0] instr;
    cond_e              cond;
    logic               cond_ok;
    logic               do_jump;
    logic [pc_w-1:0]    pc_next;

    assign instr = rom_word(pc);          // Fetch is combinational

    // Field split
    assign cond         = cond_e'(instr[cond_pos +: cond_w]);
    assign targ         = targ_e'(instr[targ_pos +: targ_w]);
    assign a_sel        = adev_e'(instr[a_sel_pos +: adev_w]);
    assign b_sel        = bdev_e'(instr[b_sel_pos +: bdev_w]);
    assign alu_op       = alu_op_e'(instr[alu_op_pos +: alu_op_w]);
    assign addr_mode    = addr_mode_e'(instr[addr_mode_pos]);
    assign immed8       = instr[immed8_pos +: data_w];
    assign direct_addr8 = instr[direct_addr8_pos +: data_w];

    // The program polls the port levels itself, a read is just a decode
    assign rx_rd = (a_sel == adev_uart_rx);

    // Jump condition, flags plus the live port levels
    always_comb begin
        case (cond)
            cond_always: cond_ok = 1'b1;
            cond_c:      cond_ok = flags[flag_c];
            cond_z:      cond_ok = flags[flag_z];
            cond_n:      cond_ok = flags[flag_n];
            cond_o:      cond_ok = flags[flag_o];
            cond_eq:     cond_ok = flags[flag_eq];
            cond_ne:     cond_ok = flags[flag_ne];
            cond_gt:     cond_ok = flags[flag_gt];
            cond_lt:     cond_ok = flags[flag_lt];
            cond_di:     cond_ok = rx_avail;        // Byte waiting
            cond_nd:     cond_ok = !rx_avail;       // Nothing yet
            cond_do_rdy: cond_ok = tx_ready;
            default:     cond_ok = 1'b0;            // Unused codes never jump
        endcase
    end

    assign do_jump = (targ == targ_pc) && cond_ok;

    always_comb begin
        if (do_jump) begin
            pc_next = result;
        end else begin
            pc_next = pc + pc_w'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // The flag register would be skipped on a pc target, so a compare there is lost
    a_no_cmp_jump: assert property (@(posedge clk) disable iff (rst)
        targ == targ_pc |-> alu_op != cmp);

endmodule

//--- verilog/cpu_pkg.sv
package cpu_pkg;

    localparam int data_w    = 8;             // Data path width
    localparam int pc_w      = 8;             // Program counter, 256 ROM words
    localparam int instr_w   = 40;            // Horizontal microcode word
    localparam int num_regs  = 4;             // General registers a to d
    localparam int ram_depth = 256;           // Bytes of data RAM

    // Field widths
    localparam int cond_w   = 4;
    localparam int targ_w   = 4;
    localparam int adev_w   = 3;
    localparam int bdev_w   = 3;
    localparam int alu_op_w = 4;

    // Field positions in the instruction word, lsb of each
    localparam int cond_pos         = 36;
    localparam int targ_pos         = 32;
    localparam int a_sel_pos        = 29;
    localparam int b_sel_pos        = 26;
    localparam int alu_op_pos       = 22;
    localparam int addr_mode_pos    = 21;     // Bits 20..16 spare
    localparam int immed8_pos       = 8;
    localparam int direct_addr8_pos = 0;

    typedef enum logic [alu_op_w-1:0] {
        pass_a, pass_b, add, adc, sub, and_op, or_op, xor_op, inc_a, dec_a,
        cmp                                   // a-b for flags, no target written
    } alu_op_e;

    typedef enum logic [adev_w-1:0] {
        adev_rega, adev_regb, adev_regc, adev_regd,
        adev_marlo, adev_marhi, adev_uart_rx, adev_zero
    } adev_e;

    typedef enum logic [bdev_w-1:0] {
        bdev_rega, bdev_regb, bdev_regc, bdev_regd,
        bdev_immed, bdev_ram, bdev_marlo, bdev_marhi
    } bdev_e;

    // Register targets first so the low bits index the register file
    typedef enum logic [targ_w-1:0] {
        targ_rega, targ_regb, targ_regc, targ_regd, targ_marlo, targ_marhi,
        targ_ram, targ_uart_tx, targ_pc, targ_none
    } targ_e;

    typedef enum logic [cond_w-1:0] {
        cond_always, cond_c, cond_z, cond_n, cond_o, cond_eq, cond_ne, cond_gt,
        cond_lt, cond_di, cond_nd, cond_do_rdy
    } cond_e;

    typedef enum logic {
        reg_mode,                             // RAM address from MARLO
        direct_mode                           // RAM address from the instruction
    } addr_mode_e;

    // Flag register bit positions, czon then GLEN
    localparam int flag_c  = 7;
    localparam int flag_z  = 6;
    localparam int flag_o  = 5;
    localparam int flag_n  = 4;
    localparam int flag_gt = 3;
    localparam int flag_lt = 2;
    localparam int flag_eq = 1;
    localparam int flag_ne = 0;

    localparam logic [data_w-1:0] ram_a_addr = 8'h10;   // Where operand a is parked

    // Program labels
    localparam logic [pc_w-1:0] lbl_wait_a  = 8'd0;
    localparam logic [pc_w-1:0] lbl_wait_b  = 8'd2;
    localparam logic [pc_w-1:0] lbl_tx1     = 8'd8;
    localparam logic [pc_w-1:0] lbl_tx1_go  = 8'd10;
    localparam logic [pc_w-1:0] lbl_tx2     = 8'd12;
    localparam logic [pc_w-1:0] lbl_tx2_go  = 8'd14;
    localparam logic [pc_w-1:0] lbl_pick_b  = 8'd19;
    localparam logic [pc_w-1:0] lbl_tx3     = 8'd20;
    localparam logic [pc_w-1:0] lbl_tx3_go  = 8'd22;

endpackage

//--- include/program_image.svh
`ifndef PROGRAM_IMAGE_SVH
`define PROGRAM_IMAGE_SVH

// Packs one microcode word
function automatic logic [instr_w-1:0] mk_instr(
    input cond_e             c,
    input targ_e             t,
    input adev_e             a,
    input bdev_e             b,
    input alu_op_e           op,
    input addr_mode_e        mode,
    input logic [data_w-1:0] imm,
    input logic [data_w-1:0] dir
);
    logic [instr_w-1:0] w;
    w = '0;
    w[cond_pos +: cond_w]        = c;
    w[targ_pos +: targ_w]        = t;
    w[a_sel_pos +: adev_w]       = a;
    w[b_sel_pos +: bdev_w]       = b;
    w[alu_op_pos +: alu_op_w]    = op;
    w[addr_mode_pos]             = mode;
    w[immed8_pos +: data_w]      = imm;
    w[direct_addr8_pos +: data_w] = dir;
    return w;
endfunction

// Jump loads the PC from the immediate passed through the ALU
function automatic logic [instr_w-1:0] jmp(input cond_e c, input logic [pc_w-1:0] to);
    return mk_instr(c, targ_pc, adev_zero, bdev_immed, pass_b, reg_mode, to, '0);
endfunction

// Plain ALU step, register addressing, no constants
function automatic logic [instr_w-1:0] alu(input targ_e t, input adev_e a, input bdev_e b,
                                           input alu_op_e op);
    return mk_instr(cond_always, t, a, b, op, reg_mode, '0, '0);
endfunction

function automatic logic [instr_w-1:0] rom_word(input logic [pc_w-1:0] addr);
    case (addr)
        8'd0:    return jmp(cond_nd, lbl_wait_a);                        // Spin for a
        8'd1:    return alu(targ_rega, adev_uart_rx, bdev_rega, pass_a);  // a <= port
        8'd2:    return jmp(cond_nd, lbl_wait_b);                        // Spin for b
        8'd3:    return alu(targ_regb, adev_uart_rx, bdev_rega, pass_a);  // b <= port
        8'd4:    return mk_instr(cond_always, targ_ram, adev_rega, bdev_rega, pass_a,
                                 direct_mode, '0, ram_a_addr);           // Park a, direct
        8'd5:    return mk_instr(cond_always, targ_marlo, adev_zero, bdev_immed, pass_b,
                                 reg_mode, ram_a_addr, '0);              // MARLO <= 0x10
        8'd6:    return alu(targ_regc, adev_zero, bdev_ram, pass_b);      // c <= RAM[MAR]
        8'd7:    return alu(targ_regd, adev_regc, bdev_regb, add);        // d <= a+b
        8'd8:    return jmp(cond_do_rdy, lbl_tx1_go);
        8'd9:    return jmp(cond_always, lbl_tx1);
        8'd10:   return alu(targ_uart_tx, adev_regd, bdev_rega, pass_a);
        8'd11:   return alu(targ_regd, adev_regc, bdev_regb, sub);        // d <= a-b
        8'd12:   return jmp(cond_do_rdy, lbl_tx2_go);
        8'd13:   return jmp(cond_always, lbl_tx2);
        8'd14:   return alu(targ_uart_tx, adev_regd, bdev_rega, pass_a);
        8'd15:   return alu(targ_none, adev_regc, bdev_regb, cmp);        // Flags of a-b
        8'd16:   return jmp(cond_lt, lbl_pick_b);
        8'd17:   return alu(targ_regd, adev_regc, bdev_regb, pass_a);     // a wins ties
        8'd18:   return jmp(cond_always, lbl_tx3);
        8'd19:   return alu(targ_regd, adev_zero, bdev_regb, pass_b);
        8'd20:   return jmp(cond_do_rdy, lbl_tx3_go);
        8'd21:   return jmp(cond_always, lbl_tx3);
        8'd22:   return alu(targ_uart_tx, adev_regd, bdev_rega, pass_a);
        default: return jmp(cond_always, lbl_wait_a);                    // Next pair
    endcase
endfunction

`endif
